// ==== src/ctrlUnit_macros.svh ====
`ifndef CTRL_UNIT_MACROS_SVH
`define CTRL_UNIT_MACROS_SVH

`define OP_RTYPE    6'b000000 // Also jr and jalr
`define OP_REGIMM   6'b000001 // bltz and bgez, selected by rt
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

`define FUNCT_SLL   6'b000000
`define FUNCT_SRL   6'b000010
`define FUNCT_SRA   6'b000011
`define FUNCT_SLLV  6'b000100
`define FUNCT_SRLV  6'b000110
`define FUNCT_SRAV  6'b000111
`define FUNCT_JR    6'b001000
`define FUNCT_JALR  6'b001001
`define FUNCT_ADD   6'b100000
`define FUNCT_ADDU  6'b100001
`define FUNCT_SUB   6'b100010
`define FUNCT_SUBU  6'b100011
`define FUNCT_AND   6'b100100
`define FUNCT_OR    6'b100101
`define FUNCT_XOR   6'b100110
`define FUNCT_NOR   6'b100111
`define FUNCT_SLT   6'b101010
`define FUNCT_SLTU  6'b101011

`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001

`endif

// ==== src/ctrlPkg.sv ====
package ctrlPkg;

    typedef logic [5:0] opcodeT;  // Instr[31:26]
    typedef logic [5:0] functT;   // Instr[5:0]
    typedef logic [4:0] regSelT;  // Register number

    typedef enum logic [5:0] {
        kindIllegal,
        kindAdd, kindAddu, kindSub, kindSubu,
        kindSll, kindSrl, kindSra, kindSllv, kindSrlv, kindSrav,
        kindAnd, kindOr, kindXor, kindNor, kindSlt, kindSltu,
        kindJr, kindJalr,
        kindAddi, kindAddiu, kindSlti, kindSltiu,
        kindAndi, kindOri, kindXori, kindLui,
        kindLw, kindLb, kindLbu, kindLh, kindLhu,
        kindSw, kindSh, kindSb,
        kindBeq, kindBne, kindBlez, kindBgtz, kindBltz, kindBgez,
        kindJ, kindJal
    } instrKindE;

    typedef enum logic [4:0] {
        aluNop, aluAdd, aluSub, aluSll, aluSrl, aluSra,
        aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu,
        aluAndi, aluOri, aluXori, aluLui,
        aluBeq, aluBne, aluBlez, aluBgtz, aluBltz, aluBgez // Compares for the branch unit
    } aluOpE;

    typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDstE;  // dstLink is r31
    typedef enum logic [1:0] {wbAluResult, wbMemData, wbPcPlus4} memtoRegE;
    typedef enum logic [1:0] {srcARegRs, srcAShamt} aluSrcAE;
    typedef enum logic [1:0] {srcBRegRt, srcBImm} aluSrcBE;
    typedef enum logic [1:0] {npcSeq, npcBranch, npcJump} npcTypeE;
    typedef enum logic {jmpTarget, jmpRegister} jumpSrcE; // Register means PC = GPR[rs]

    typedef enum logic [2:0] {rdNone, rdLw, rdLb, rdLbu, rdLh, rdLhu} memRdE;
    typedef enum logic [1:0] {wrNone, wrSw, wrSh, wrSb} memWrE;

endpackage

// ==== src/ctrlWordIf.sv ====
`timescale 1ns/1ps

interface ctrlWordIf;

    logic               regWrite;
    ctrlPkg::regDstE    regDst;
    ctrlPkg::memtoRegE  memtoReg;
    ctrlPkg::aluOpE     aluOp;
    ctrlPkg::aluSrcAE   aluSrcA;
    ctrlPkg::aluSrcBE   aluSrcB;

    logic               memRead;
    logic               memWrite;
    ctrlPkg::memRdE     memRdType;
    ctrlPkg::memWrE     memWrType;
    ctrlPkg::npcTypeE   npcType;
    logic               pcSrc;
    ctrlPkg::jumpSrcE   jumpSrc;
    logic               illegal;

    modport datapathSrc (output regWrite, regDst, memtoReg, aluOp, aluSrcA, aluSrcB);

    modport flowSrc (output memRead, memWrite, memRdType, memWrType,
                     npcType, pcSrc, jumpSrc, illegal);

    modport sink (input regWrite, regDst, memtoReg, aluOp, aluSrcA, aluSrcB,
                  memRead, memWrite, memRdType, memWrType,
                  npcType, pcSrc, jumpSrc, illegal);

endinterface

// ==== src/instrClassify.sv ====
`timescale 1ns/1ps
`include "ctrlUnit_macros.svh"

module instrClassify (
    input  ctrlPkg::opcodeT    opcode,
    input  ctrlPkg::functT     funct,
    input  ctrlPkg::regSelT    rt,
    output ctrlPkg::instrKindE instrKind
);

    always_comb
    begin
        instrKind = ctrlPkg::kindIllegal; // Anything not matched below
        case (opcode)
            `OP_RTYPE:
            begin
                case (funct)
                    `FUNCT_ADD:  instrKind = ctrlPkg::kindAdd;
                    `FUNCT_ADDU: instrKind = ctrlPkg::kindAddu;
                    `FUNCT_SUB:  instrKind = ctrlPkg::kindSub;
                    `FUNCT_SUBU: instrKind = ctrlPkg::kindSubu;
                    `FUNCT_SLL:  instrKind = ctrlPkg::kindSll;
                    `FUNCT_SRL:  instrKind = ctrlPkg::kindSrl;
                    `FUNCT_SRA:  instrKind = ctrlPkg::kindSra;
                    `FUNCT_SLLV: instrKind = ctrlPkg::kindSllv;
                    `FUNCT_SRLV: instrKind = ctrlPkg::kindSrlv;
                    `FUNCT_SRAV: instrKind = ctrlPkg::kindSrav;
                    `FUNCT_AND:  instrKind = ctrlPkg::kindAnd;
                    `FUNCT_OR:   instrKind = ctrlPkg::kindOr;
                    `FUNCT_XOR:  instrKind = ctrlPkg::kindXor;
                    `FUNCT_NOR:  instrKind = ctrlPkg::kindNor;
                    `FUNCT_SLT:  instrKind = ctrlPkg::kindSlt;
                    `FUNCT_SLTU: instrKind = ctrlPkg::kindSltu;
                    `FUNCT_JR:   instrKind = ctrlPkg::kindJr;
                    `FUNCT_JALR: instrKind = ctrlPkg::kindJalr;
                    default:     instrKind = ctrlPkg::kindIllegal;
                endcase
            end
            `OP_REGIMM:
            begin
                case (rt)
                    `RT_BLTZ: instrKind = ctrlPkg::kindBltz;
                    `RT_BGEZ: instrKind = ctrlPkg::kindBgez;
                    default:  instrKind = ctrlPkg::kindIllegal; // Other regimm forms unsupported
                endcase
            end
            `OP_ADDI:  instrKind = ctrlPkg::kindAddi;
            `OP_ADDIU: instrKind = ctrlPkg::kindAddiu;
            `OP_SLTI:  instrKind = ctrlPkg::kindSlti;
            `OP_SLTIU: instrKind = ctrlPkg::kindSltiu;
            `OP_ANDI:  instrKind = ctrlPkg::kindAndi;
            `OP_ORI:   instrKind = ctrlPkg::kindOri;
            `OP_XORI:  instrKind = ctrlPkg::kindXori;
            `OP_LUI:   instrKind = ctrlPkg::kindLui;
            `OP_LW:    instrKind = ctrlPkg::kindLw;
            `OP_LB:    instrKind = ctrlPkg::kindLb;
            `OP_LBU:   instrKind = ctrlPkg::kindLbu;
            `OP_LH:    instrKind = ctrlPkg::kindLh;
            `OP_LHU:   instrKind = ctrlPkg::kindLhu;
            `OP_SW:    instrKind = ctrlPkg::kindSw;
            `OP_SH:    instrKind = ctrlPkg::kindSh;
            `OP_SB:    instrKind = ctrlPkg::kindSb;
            `OP_BEQ:   instrKind = ctrlPkg::kindBeq;
            `OP_BNE:   instrKind = ctrlPkg::kindBne;
            `OP_BLEZ:  instrKind = ctrlPkg::kindBlez;
            `OP_BGTZ:  instrKind = ctrlPkg::kindBgtz;
            `OP_J:     instrKind = ctrlPkg::kindJ;
            `OP_JAL:   instrKind = ctrlPkg::kindJal;
            default:   instrKind = ctrlPkg::kindIllegal;
        endcase
    end

    // Known fields must always map to a defined kind
    always_comb
    begin
        assert final ($isunknown({opcode, funct, rt}) || !$isunknown(instrKind));
    end

endmodule

// ==== src/datapathDecode.sv ====
`timescale 1ns/1ps

module datapathDecode (
    input  ctrlPkg::instrKindE instrKind,
    ctrlWordIf.datapathSrc     word
);

    // ALU operation, named after the instruction
    always_comb
    begin
        case (instrKind)
            ctrlPkg::kindAdd, ctrlPkg::kindAddu,
            ctrlPkg::kindAddi, ctrlPkg::kindAddiu,
            ctrlPkg::kindLw, ctrlPkg::kindLb, ctrlPkg::kindLbu,
            ctrlPkg::kindLh, ctrlPkg::kindLhu,
            ctrlPkg::kindSw, ctrlPkg::kindSh, ctrlPkg::kindSb:
                word.aluOp = ctrlPkg::aluAdd; // Also address calculation
            ctrlPkg::kindSub, ctrlPkg::kindSubu:  word.aluOp = ctrlPkg::aluSub;
            ctrlPkg::kindSll, ctrlPkg::kindSllv:  word.aluOp = ctrlPkg::aluSll;
            ctrlPkg::kindSrl, ctrlPkg::kindSrlv:  word.aluOp = ctrlPkg::aluSrl;
            ctrlPkg::kindSra, ctrlPkg::kindSrav:  word.aluOp = ctrlPkg::aluSra;
            ctrlPkg::kindAnd:                     word.aluOp = ctrlPkg::aluAnd;
            ctrlPkg::kindOr:                      word.aluOp = ctrlPkg::aluOr;
            ctrlPkg::kindXor:                     word.aluOp = ctrlPkg::aluXor;
            ctrlPkg::kindNor:                     word.aluOp = ctrlPkg::aluNor;
            ctrlPkg::kindSlt, ctrlPkg::kindSlti:  word.aluOp = ctrlPkg::aluSlt;
            ctrlPkg::kindSltu, ctrlPkg::kindSltiu: word.aluOp = ctrlPkg::aluSltu;
            ctrlPkg::kindAndi:                    word.aluOp = ctrlPkg::aluAndi;
            ctrlPkg::kindOri:                     word.aluOp = ctrlPkg::aluOri;
            ctrlPkg::kindXori:                    word.aluOp = ctrlPkg::aluXori;
            ctrlPkg::kindLui:                     word.aluOp = ctrlPkg::aluLui;
            ctrlPkg::kindBeq:                     word.aluOp = ctrlPkg::aluBeq;
            ctrlPkg::kindBne:                     word.aluOp = ctrlPkg::aluBne;
            ctrlPkg::kindBlez:                    word.aluOp = ctrlPkg::aluBlez;
            ctrlPkg::kindBgtz:                    word.aluOp = ctrlPkg::aluBgtz;
            ctrlPkg::kindBltz:                    word.aluOp = ctrlPkg::aluBltz;
            ctrlPkg::kindBgez:                    word.aluOp = ctrlPkg::aluBgez;
            default:                              word.aluOp = ctrlPkg::aluNop;
        endcase
    end

    // Writeback and operand selects
    always_comb
    begin
        word.regWrite = 1'b0;
        word.regDst   = ctrlPkg::dstRt;
        word.memtoReg = ctrlPkg::wbAluResult;
        word.aluSrcA  = ctrlPkg::srcARegRs;
        word.aluSrcB  = ctrlPkg::srcBRegRt; // Branches compare rs with rt
        case (instrKind)
            ctrlPkg::kindSll, ctrlPkg::kindSrl, ctrlPkg::kindSra:
            begin
                word.regWrite = 1'b1;
                word.regDst   = ctrlPkg::dstRd;
                word.aluSrcA  = ctrlPkg::srcAShamt; // Constant shift amount
            end
            ctrlPkg::kindAdd, ctrlPkg::kindAddu, ctrlPkg::kindSub, ctrlPkg::kindSubu,
            ctrlPkg::kindSllv, ctrlPkg::kindSrlv, ctrlPkg::kindSrav,
            ctrlPkg::kindAnd, ctrlPkg::kindOr, ctrlPkg::kindXor, ctrlPkg::kindNor,
            ctrlPkg::kindSlt, ctrlPkg::kindSltu:
            begin
                word.regWrite = 1'b1;
                word.regDst   = ctrlPkg::dstRd;
            end
            ctrlPkg::kindAddi, ctrlPkg::kindAddiu, ctrlPkg::kindSlti, ctrlPkg::kindSltiu,
            ctrlPkg::kindAndi, ctrlPkg::kindOri, ctrlPkg::kindXori, ctrlPkg::kindLui:
            begin
                word.regWrite = 1'b1;
                word.aluSrcB  = ctrlPkg::srcBImm;
            end
            ctrlPkg::kindLw, ctrlPkg::kindLb, ctrlPkg::kindLbu,
            ctrlPkg::kindLh, ctrlPkg::kindLhu:
            begin
                word.regWrite = 1'b1;
                word.memtoReg = ctrlPkg::wbMemData;
                word.aluSrcB  = ctrlPkg::srcBImm;
            end
            ctrlPkg::kindSw, ctrlPkg::kindSh, ctrlPkg::kindSb:
                word.aluSrcB = ctrlPkg::srcBImm;
            ctrlPkg::kindJal, ctrlPkg::kindJalr:
            begin
                word.regWrite = 1'b1;
                word.regDst   = ctrlPkg::dstLink; // r31 gets the return address
                word.memtoReg = ctrlPkg::wbPcPlus4;
            end
            default:
                word.regWrite = 1'b0;
        endcase
    end

endmodule

// ==== src/flowMemDecode.sv ====
`timescale 1ns/1ps

module flowMemDecode (
    input  ctrlPkg::instrKindE instrKind,
    ctrlWordIf.flowSrc         word
);

    always_comb
    begin
        word.memRdType = ctrlPkg::rdNone;
        word.memWrType = ctrlPkg::wrNone;
        word.npcType   = ctrlPkg::npcSeq;    // Illegal kind stays sequential
        word.jumpSrc   = ctrlPkg::jmpTarget;
        case (instrKind)
            ctrlPkg::kindLw:  word.memRdType = ctrlPkg::rdLw;
            ctrlPkg::kindLb:  word.memRdType = ctrlPkg::rdLb;
            ctrlPkg::kindLbu: word.memRdType = ctrlPkg::rdLbu;
            ctrlPkg::kindLh:  word.memRdType = ctrlPkg::rdLh;
            ctrlPkg::kindLhu: word.memRdType = ctrlPkg::rdLhu;
            ctrlPkg::kindSw:  word.memWrType = ctrlPkg::wrSw;
            ctrlPkg::kindSh:  word.memWrType = ctrlPkg::wrSh;
            ctrlPkg::kindSb:  word.memWrType = ctrlPkg::wrSb;
            ctrlPkg::kindBeq, ctrlPkg::kindBne, ctrlPkg::kindBlez,
            ctrlPkg::kindBgtz, ctrlPkg::kindBltz, ctrlPkg::kindBgez:
                word.npcType = ctrlPkg::npcBranch; // Resolved by the EX branch unit
            ctrlPkg::kindJ, ctrlPkg::kindJal:
                word.npcType = ctrlPkg::npcJump;
            ctrlPkg::kindJr, ctrlPkg::kindJalr:
            begin
                word.npcType = ctrlPkg::npcJump;
                word.jumpSrc = ctrlPkg::jmpRegister; // PC = GPR[rs]
            end
            default:
                word.npcType = ctrlPkg::npcSeq;
        endcase
    end

    // Enables follow from the selected types
    assign word.memRead  = (word.memRdType != ctrlPkg::rdNone);
    assign word.memWrite = (word.memWrType != ctrlPkg::wrNone);
    assign word.pcSrc    = (word.npcType == ctrlPkg::npcBranch);
    assign word.illegal  = (instrKind == ctrlPkg::kindIllegal);

    // A single instruction never reads and writes memory
    always_comb
    begin
        assert final (!(word.memRead && word.memWrite));
    end

endmodule

// ==== src/ctrlHandshake.sv ====
`timescale 1ns/1ps

module ctrlHandshake (
    input  logic               clk,
    input  logic               arstN,
    input  logic               req,
    ctrlWordIf.sink            word,
    output logic               ack,
    output logic               regWrite,
    output ctrlPkg::regDstE    regDst,
    output ctrlPkg::memtoRegE  memtoReg,
    output ctrlPkg::aluOpE     aluOp,
    output ctrlPkg::aluSrcAE   aluSrcA,
    output ctrlPkg::aluSrcBE   aluSrcB,
    output logic               memRead,
    output logic               memWrite,
    output ctrlPkg::memRdE     memRdType,
    output ctrlPkg::memWrE     memWrType,
    output ctrlPkg::npcTypeE   npcType,
    output logic               pcSrc,
    output ctrlPkg::jumpSrcE   jumpSrc,
    output logic               illegalInstr
);

    typedef enum logic {stIdle, stAckHigh} hsStateE;

    hsStateE state;
    logic    capture;

    assign capture = (state == stIdle) && req; // New request seen
    assign ack     = (state == stAckHigh);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            state <= stIdle;
        else if (capture)
            state <= stAckHigh;
        else if (ack && !req)
            state <= stIdle; // Requester has dropped req
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            {regWrite, memRead, memWrite, pcSrc, illegalInstr} <= '0;
            regDst    <= ctrlPkg::dstRt;
            memtoReg  <= ctrlPkg::wbAluResult;
            aluOp     <= ctrlPkg::aluNop;
            aluSrcA   <= ctrlPkg::srcARegRs;
            aluSrcB   <= ctrlPkg::srcBRegRt;
            memRdType <= ctrlPkg::rdNone;
            memWrType <= ctrlPkg::wrNone;
            npcType   <= ctrlPkg::npcSeq;
            jumpSrc   <= ctrlPkg::jmpTarget;
        end
        else if (capture)
        begin
            regWrite     <= word.regWrite;
            regDst       <= word.regDst;
            memtoReg     <= word.memtoReg;
            aluOp        <= word.aluOp;
            aluSrcA      <= word.aluSrcA;
            aluSrcB      <= word.aluSrcB;
            memRead      <= word.memRead;
            memWrite     <= word.memWrite;
            memRdType    <= word.memRdType;
            memWrType    <= word.memWrType;
            npcType      <= word.npcType;
            pcSrc        <= word.pcSrc;
            jumpSrc      <= word.jumpSrc;
            illegalInstr <= word.illegal;
        end
    end

    ackAfterReq: assert property (@(posedge clk) disable iff (!arstN)
        $rose(ack) |-> $past(req));

    // Held word must not move while the requester can still sample it
    stableWhileAck: assert property (@(posedge clk) disable iff (!arstN)
        ack |=> $stable({regWrite, regDst, memtoReg, aluOp, aluSrcA, aluSrcB, memRead,
                         memWrite, memRdType, memWrType, npcType, pcSrc, jumpSrc,
                         illegalInstr}));

    illegalIsSafe: assert property (@(posedge clk) disable iff (!arstN)
        illegalInstr |-> !(regWrite || memRead || memWrite));

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  logic               clk,
    input  logic               arstN,
    input  logic               req,
    input  ctrlPkg::opcodeT    opcode,
    input  ctrlPkg::functT     funct,
    input  ctrlPkg::regSelT    rt,
    output logic               ack,
    output logic               regWrite,
    output ctrlPkg::regDstE    regDst,
    output ctrlPkg::memtoRegE  memtoReg,
    output ctrlPkg::aluOpE     aluOp,
    output ctrlPkg::aluSrcAE   aluSrcA,
    output ctrlPkg::aluSrcBE   aluSrcB,
    output logic               memRead,
    output logic               memWrite,
    output ctrlPkg::memRdE     memRdType,
    output ctrlPkg::memWrE     memWrType,
    output ctrlPkg::npcTypeE   npcType,
    output logic               pcSrc,
    output ctrlPkg::jumpSrcE   jumpSrc,
    output logic               illegalInstr
);

    ctrlPkg::instrKindE instrKind;

    ctrlWordIf word (); // Combinational control word

    instrClassify uClassify (
        .opcode    (opcode),
        .funct     (funct),
        .rt        (rt),
        .instrKind (instrKind)
    );

    datapathDecode uDatapath (
        .instrKind (instrKind),
        .word      (word.datapathSrc)
    );

    flowMemDecode uFlowMem (
        .instrKind (instrKind),
        .word      (word.flowSrc)
    );

    ctrlHandshake uHandshake (
        .clk          (clk),
        .arstN        (arstN),
        .req          (req),
        .word         (word.sink),
        .ack          (ack),
        .regWrite     (regWrite),
        .regDst       (regDst),
        .memtoReg     (memtoReg),
        .aluOp        (aluOp),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memRdType    (memRdType),
        .memWrType    (memWrType),
        .npcType      (npcType),
        .pcSrc        (pcSrc),
        .jumpSrc      (jumpSrc),
        .illegalInstr (illegalInstr)
    );

endmodule

// ==== tb/clkRstGen.sv ====
`timescale 1ns/1ps

module clkRstGen (
    output logic clk,
    output logic arstN
);

    localparam int resetCycles = 8;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial
    begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #2 arstN = 1'b1; // Released clear of the clock edge
    end

endmodule

// ==== tb/controlUnitTb.sv ====
`timescale 1ns/1ps
`include "ctrlUnit_macros.svh"

module controlUnitTb;

    localparam int resetCycles = 8;

    typedef struct packed {
        ctrlPkg::opcodeT   opcode;
        ctrlPkg::functT    funct;
        ctrlPkg::regSelT   rt;
        logic              randFunct;  // Funct ignored, drive random
        logic              randRt;     // Rt ignored, drive random
        logic              regWrite;
        ctrlPkg::regDstE   regDst;
        ctrlPkg::memtoRegE memtoReg;
        ctrlPkg::aluOpE    aluOp;
        ctrlPkg::aluSrcAE  aluSrcA;
        ctrlPkg::aluSrcBE  aluSrcB;
        logic              memRead;
        logic              memWrite;
        ctrlPkg::memRdE    memRdType;
        ctrlPkg::memWrE    memWrType;
        ctrlPkg::npcTypeE  npcType;
        logic              pcSrc;
        ctrlPkg::jumpSrcE  jumpSrc;
        logic              illegal;
    } rowT;

    logic               clk;
    logic               arstN;
    logic               req;
    ctrlPkg::opcodeT    opcode;
    ctrlPkg::functT     funct;
    ctrlPkg::regSelT    rt;
    logic               ack;
    logic               regWrite;
    ctrlPkg::regDstE    regDst;
    ctrlPkg::memtoRegE  memtoReg;
    ctrlPkg::aluOpE     aluOp;
    ctrlPkg::aluSrcAE   aluSrcA;
    ctrlPkg::aluSrcBE   aluSrcB;
    logic               memRead;
    logic               memWrite;
    ctrlPkg::memRdE     memRdType;
    ctrlPkg::memWrE     memWrType;
    ctrlPkg::npcTypeE   npcType;
    logic               pcSrc;
    ctrlPkg::jumpSrcE   jumpSrc;
    logic               illegalInstr;

    rowT    rows[$];
    integer seed = 74903;
    int     cycles = 0;
    int     timeoutLimit = 1000;

    clkRstGen uClkRst (
        .clk   (clk),
        .arstN (arstN)
    );

    controlUnit u_dut (
        .clk          (clk),
        .arstN        (arstN),
        .req          (req),
        .opcode       (opcode),
        .funct        (funct),
        .rt           (rt),
        .ack          (ack),
        .regWrite     (regWrite),
        .regDst       (regDst),
        .memtoReg     (memtoReg),
        .aluOp        (aluOp),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memRdType    (memRdType),
        .memWrType    (memWrType),
        .npcType      (npcType),
        .pcSrc        (pcSrc),
        .jumpSrc      (jumpSrc),
        .illegalInstr (illegalInstr)
    );

    task automatic stopWithFailure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal)
        else stopWithFailure($sformatf("error at %0d ns: %s expected %0h, actual %0h",
                                       $time, name, expVal, actVal));
    endtask

    task automatic checkOutputs(input rowT exp);
        assert (!(memRead && memWrite))
        else stopWithFailure("memRead and memWrite are both set at the same time");
        checkField("regWrite", exp.regWrite, regWrite);
        checkField("regDst", exp.regDst, regDst);
        checkField("memtoReg", exp.memtoReg, memtoReg);
        checkField("aluOp", exp.aluOp, aluOp);
        checkField("aluSrcA", exp.aluSrcA, aluSrcA);
        checkField("aluSrcB", exp.aluSrcB, aluSrcB);
        checkField("memRead", exp.memRead, memRead);
        checkField("memWrite", exp.memWrite, memWrite);
        checkField("memRdType", exp.memRdType, memRdType);
        checkField("memWrType", exp.memWrType, memWrType);
        checkField("npcType", exp.npcType, npcType);
        checkField("pcSrc", exp.pcSrc, pcSrc);
        checkField("jumpSrc", exp.jumpSrc, jumpSrc);
        checkField("illegalInstr", exp.illegal, illegalInstr);
    endtask

    // Every field at its zero value
    function automatic rowT blankRow(input ctrlPkg::opcodeT op, input ctrlPkg::functT fn,
                                     input ctrlPkg::regSelT r);
        rowT row;
        row           = '0;
        row.opcode    = op;
        row.funct     = fn;
        row.rt        = r;
        row.randRt    = (op == `OP_RTYPE);  // R-type ignores rt
        row.randFunct = (op == `OP_REGIMM); // Regimm ignores funct
        return row;
    endfunction

    function automatic rowT rTypeRow(input ctrlPkg::functT fn, input ctrlPkg::aluOpE alu,
                                     input logic shamtSrc);
        rowT row;
        row          = blankRow(`OP_RTYPE, fn, 5'd0);
        row.regWrite = 1'b1;
        row.regDst   = ctrlPkg::dstRd;
        row.aluOp    = alu;
        if (shamtSrc)
            row.aluSrcA = ctrlPkg::srcAShamt;
        return row;
    endfunction

    function automatic rowT immRow(input ctrlPkg::opcodeT op, input ctrlPkg::aluOpE alu);
        rowT row;
        row          = blankRow(op, 6'd0, 5'd0);
        row.regWrite = 1'b1;
        row.aluSrcB  = ctrlPkg::srcBImm;
        row.aluOp    = alu;
        return row;
    endfunction

    // Loads when rdT is set, stores otherwise
    function automatic rowT memRow(input ctrlPkg::opcodeT op, input ctrlPkg::memRdE rdT,
                                   input ctrlPkg::memWrE wrT);
        rowT row;
        row         = blankRow(op, 6'd0, 5'd0);
        row.aluOp   = ctrlPkg::aluAdd;
        row.aluSrcB = ctrlPkg::srcBImm;
        if (rdT != ctrlPkg::rdNone)
        begin
            row.regWrite  = 1'b1;
            row.memtoReg  = ctrlPkg::wbMemData;
            row.memRead   = 1'b1;
            row.memRdType = rdT;
        end
        else
        begin
            row.memWrite  = 1'b1;
            row.memWrType = wrT;
        end
        return row;
    endfunction

    function automatic rowT branchRow(input ctrlPkg::opcodeT op, input ctrlPkg::regSelT r,
                                      input ctrlPkg::aluOpE alu);
        rowT row;
        row         = blankRow(op, 6'd0, r);
        row.aluOp   = alu;
        row.pcSrc   = 1'b1;
        row.npcType = ctrlPkg::npcBranch;
        return row;
    endfunction

    function automatic rowT jumpRow(input ctrlPkg::opcodeT op, input ctrlPkg::functT fn,
                                    input logic link, input logic viaReg);
        rowT row;
        row         = blankRow(op, fn, 5'd0);
        row.npcType = ctrlPkg::npcJump;
        if (link)
        begin
            row.regWrite = 1'b1;
            row.regDst   = ctrlPkg::dstLink;
            row.memtoReg = ctrlPkg::wbPcPlus4;
        end
        if (viaReg)
            row.jumpSrc = ctrlPkg::jmpRegister;
        return row;
    endfunction

    function automatic rowT illegalRow(input ctrlPkg::opcodeT op, input ctrlPkg::functT fn,
                                       input ctrlPkg::regSelT r);
        rowT row;
        row         = blankRow(op, fn, r);
        row.illegal = 1'b1;
        return row;
    endfunction

    task automatic buildTable();
        rows.push_back(rTypeRow(`FUNCT_ADD, ctrlPkg::aluAdd, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_ADDU, ctrlPkg::aluAdd, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_SUB, ctrlPkg::aluSub, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_SUBU, ctrlPkg::aluSub, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_SLL, ctrlPkg::aluSll, 1'b1));
        rows.push_back(rTypeRow(`FUNCT_SRL, ctrlPkg::aluSrl, 1'b1));
        rows.push_back(rTypeRow(`FUNCT_SRA, ctrlPkg::aluSra, 1'b1));
        rows.push_back(rTypeRow(`FUNCT_SLLV, ctrlPkg::aluSll, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_SRLV, ctrlPkg::aluSrl, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_SRAV, ctrlPkg::aluSra, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_AND, ctrlPkg::aluAnd, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_OR, ctrlPkg::aluOr, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_XOR, ctrlPkg::aluXor, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_NOR, ctrlPkg::aluNor, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_SLT, ctrlPkg::aluSlt, 1'b0));
        rows.push_back(rTypeRow(`FUNCT_SLTU, ctrlPkg::aluSltu, 1'b0));
        rows.push_back(jumpRow(`OP_RTYPE, `FUNCT_JR, 1'b0, 1'b1));
        rows.push_back(jumpRow(`OP_RTYPE, `FUNCT_JALR, 1'b1, 1'b1));
        rows.push_back(immRow(`OP_ADDI, ctrlPkg::aluAdd));
        rows.push_back(immRow(`OP_ADDIU, ctrlPkg::aluAdd));
        rows.push_back(immRow(`OP_SLTI, ctrlPkg::aluSlt));
        rows.push_back(immRow(`OP_SLTIU, ctrlPkg::aluSltu));
        rows.push_back(immRow(`OP_ANDI, ctrlPkg::aluAndi));
        rows.push_back(immRow(`OP_ORI, ctrlPkg::aluOri));
        rows.push_back(immRow(`OP_XORI, ctrlPkg::aluXori));
        rows.push_back(immRow(`OP_LUI, ctrlPkg::aluLui));
        rows.push_back(memRow(`OP_LW, ctrlPkg::rdLw, ctrlPkg::wrNone));
        rows.push_back(memRow(`OP_LB, ctrlPkg::rdLb, ctrlPkg::wrNone));
        rows.push_back(memRow(`OP_LBU, ctrlPkg::rdLbu, ctrlPkg::wrNone));
        rows.push_back(memRow(`OP_LH, ctrlPkg::rdLh, ctrlPkg::wrNone));
        rows.push_back(memRow(`OP_LHU, ctrlPkg::rdLhu, ctrlPkg::wrNone));
        rows.push_back(memRow(`OP_SW, ctrlPkg::rdNone, ctrlPkg::wrSw));
        rows.push_back(memRow(`OP_SH, ctrlPkg::rdNone, ctrlPkg::wrSh));
        rows.push_back(memRow(`OP_SB, ctrlPkg::rdNone, ctrlPkg::wrSb));
        rows.push_back(branchRow(`OP_BEQ, 5'd0, ctrlPkg::aluBeq));
        rows.push_back(branchRow(`OP_BNE, 5'd0, ctrlPkg::aluBne));
        rows.push_back(branchRow(`OP_BLEZ, 5'd0, ctrlPkg::aluBlez));
        rows.push_back(branchRow(`OP_BGTZ, 5'd0, ctrlPkg::aluBgtz));
        rows.push_back(branchRow(`OP_REGIMM, `RT_BLTZ, ctrlPkg::aluBltz));
        rows.push_back(branchRow(`OP_REGIMM, `RT_BGEZ, ctrlPkg::aluBgez));
        rows.push_back(jumpRow(`OP_J, 6'd0, 1'b0, 1'b0));
        rows.push_back(jumpRow(`OP_JAL, 6'd0, 1'b1, 1'b0));
        rows.push_back(illegalRow(6'b111111, 6'd0, 5'd0));
        rows.push_back(illegalRow(6'b010000, 6'd0, 5'd0));     // Coprocessor 0
        rows.push_back(illegalRow(6'b100010, 6'd0, 5'd0));     // lwl
        rows.push_back(illegalRow(`OP_RTYPE, 6'b011000, 5'd0)); // mult
        rows.push_back(illegalRow(`OP_RTYPE, 6'b000001, 5'd0));
        rows.push_back(illegalRow(`OP_REGIMM, 6'd0, 5'b10000)); // bltzal
    endtask

    // One full four-phase exchange, entered and left 1 ns after an edge
    task automatic runRow(input rowT exp);
        int edges;
        int extra;
        opcode = exp.opcode;
        funct  = exp.randFunct ? ctrlPkg::functT'($random(seed)) : exp.funct;
        rt     = exp.randRt ? ctrlPkg::regSelT'($random(seed)) : exp.rt;
        req    = 1'b1;
        edges  = 0;
        while (!ack)
        begin
            @(posedge clk);
            #1;
            edges++;
        end
        assert (edges == 1)
        else stopWithFailure("ack did not rise on the first edge after req");
        checkOutputs(exp);
        extra = 1 + (($random(seed) & 32'h7fff_ffff) % 5);
        repeat (extra)
        begin
            opcode = ctrlPkg::opcodeT'($random(seed)); // Must not reach the outputs
            funct  = ctrlPkg::functT'($random(seed));
            rt     = ctrlPkg::regSelT'($random(seed));
            @(posedge clk);
            #1;
            checkField("ack", 1'b1, ack);
            checkOutputs(exp);
        end
        req   = 1'b0;
        edges = 0;
        while (ack)
        begin
            @(posedge clk);
            #1;
            edges++;
        end
        assert (edges == 1)
        else stopWithFailure("ack did not fall on the first edge after req dropped");
        checkOutputs(exp); // Word held after ack falls
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > timeoutLimit)
            stopWithFailure("timeout: the handshake did not complete in the expected cycles");
    end

    initial
    begin
        req    = 1'b0;
        opcode = '0;
        funct  = '0;
        rt     = '0;
        buildTable();
        timeoutLimit = rows.size() * 8 + resetCycles + 50;
        @(posedge arstN);
        @(posedge clk);
        #1;
        checkField("ack", 1'b0, ack);
        checkOutputs(blankRow(6'd0, 6'd0, 5'd0)); // Reset word
        foreach (rows[i])
            runRow(rows[i]);
        $display("test passed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/ctrlPkg.sv
src/ctrlWordIf.sv
src/instrClassify.sv
src/datapathDecode.sv
src/flowMemDecode.sv
src/ctrlHandshake.sv
src/controlUnit.sv
tb/clkRstGen.sv
tb/controlUnitTb.sv

// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - include_dirs:
      - src
    files:
      - src/ctrlPkg.sv
      - src/ctrlWordIf.sv
      - src/instrClassify.sv
      - src/datapathDecode.sv
      - src/flowMemDecode.sv
      - src/ctrlHandshake.sv
      - src/controlUnit.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/clkRstGen.sv
      - tb/controlUnitTb.sv
